// ==== Makefile ====
# Verilator build and run of the hps_link testbench

VERILATOR ?= verilator
TOP       ?= hps_tb
FILELIST  ?= hps_link.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PS2_DIV   ?= 4
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
RUNFLAGS  ?= +verilator+error+limit+1000

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run, and check $(LOG) for a failure"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG PS2_DIV VFLAGS RUNFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -GPS2_DIV=$(PS2_DIV) \
		--Mdir $(BUILD_DIR) -o $(TOP) -f $(FILELIST)
	-./$(BUILD_DIR)/$(TOP) $(RUNFLAGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TEST PASS" $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== hps_link.f ====
+incdir+src
src/hps_bus_pkg.sv
src/hps_ps2_pkg.sv
src/hps_cmd_track.sv
src/hps_word_collect.sv
src/hps_file_loader.sv
src/ps2_clk_div.sv
src/ps2_kbd_tx.sv
src/hps_link.sv
verif/hps_sva.sv
verif/hps_tb_clk.sv
verif/hps_tb.sv

// ==== src/hps_bus_pkg.sv ====
/*
 * Command-bus types: bus word, word index, command code enum and
 * the payload types of the cfg, joystick, status and download registers.
 */
`default_nettype none

`include "hps_defs.svh"

package hps_bus_pkg;

	typedef logic [`HPS_WORD_W-1:0] word_t;
	typedef logic [`HPS_IDX_W-1:0] word_idx_t;

	// command codes sent as the first word of a frame
	typedef enum logic [`HPS_WORD_W-1:0] {
		NONE        = 16'h0000,
		CFG         = 16'h0001,
		JOY0        = 16'h0002,
		JOY1        = 16'h0003,
		PS2_KBD     = 16'h0005,
		STATUS      = 16'h001E,
		FILE_TX     = 16'h0053,
		FILE_TX_DAT = 16'h0054,
		FILE_INDEX  = 16'h0055,
		FILE_INFO   = 16'h0056
	} cmd_e;

	typedef logic [15:0] cfg_t;
	typedef logic [31:0] joy_t;
	typedef logic [63:0] status_t;
	typedef logic [`HPS_ADDR_W-1:0] dl_addr_t;

endpackage

`default_nettype wire

// ==== src/hps_cmd_track.sv ====
/*
 * Command framing: latches the command code on the first strobe of a
 * frame, then numbers and re-emits each data word with a strobe.
 */
`timescale 1ns/1ps
`default_nettype none

module hps_cmd_track (
	input  wire                   clk_sys,
	input  wire                   reset,
	input  wire                   io_enable,
	input  wire                   io_strobe,
	input  hps_bus_pkg::word_t    io_din,
	output hps_bus_pkg::cmd_e     cmd,
	output hps_bus_pkg::word_idx_t word_idx,
	output hps_bus_pkg::word_t    word,
	output logic                  word_stb
);
	import hps_bus_pkg::*;

	typedef enum logic {
		WAIT_CMD,
		DATA
	} trk_state_e;

	trk_state_e state;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			state    <= WAIT_CMD;
			cmd      <= NONE;
			word_idx <= '0;
			word_stb <= 1'b0;
		end else begin
			word_stb <= 1'b0;
			if (!io_enable) begin
				// frame closed, next strobe is a new command code
				state    <= WAIT_CMD;
				cmd      <= NONE;
				word_idx <= '0;
			end else if (io_strobe) begin
				case (state)
					WAIT_CMD: begin
						cmd      <= cmd_e'(io_din);
						word_idx <= '0;
						state    <= DATA;
					end
					DATA: begin
						// index sticks at its maximum on very long frames
						if (word_idx != '1)
							word_idx <= word_idx + 1'b1;
						word_stb <= 1'b1;
					end
				endcase
			end
		end
	end

	// data word follows the strobe by one cycle
	always_ff @(posedge clk_sys) begin
		if (io_enable && io_strobe && state == DATA)
			word <= io_din;
	end

endmodule

`default_nettype wire

// ==== src/hps_defs.svh ====
/*
 * Shared width and sizing macros for the host command-bus bridge:
 * bus word, download address and word-index widths, PS/2 clock divider
 * and keyboard FIFO depth.
 */
`ifndef HPS_DEFS_SVH
`define HPS_DEFS_SVH

// host bus word
`define HPS_WORD_W 16

// byte address of the file download
`define HPS_ADDR_W 27

// data-word number inside one command, saturating
`define HPS_IDX_W 10

// system clocks per PS/2 clock half-period, minus one
`define HPS_PS2_DIV 1000

// keyboard FIFO holds 2**bits bytes
`define HPS_PS2_FIFO_BITS 5

`endif

// ==== src/hps_file_loader.sv ====
/*
 * File download to the core: index, extension, start/stop control
 * and byte writes with an incrementing address.
 */
`timescale 1ns/1ps
`default_nettype none

module hps_file_loader (
	input  wire                    clk_sys,
	input  wire                    reset,
	input  hps_bus_pkg::cmd_e      cmd,
	input  hps_bus_pkg::word_idx_t word_idx,
	input  hps_bus_pkg::word_t     word,
	input  wire                    word_stb,
	output logic                   ioctl_download,
	output logic [7:0]             ioctl_index,
	output logic [31:0]            ioctl_file_ext,
	output logic                   ioctl_wr,
	output hps_bus_pkg::dl_addr_t  ioctl_addr,
	output logic [7:0]             ioctl_dout
);
	import hps_bus_pkg::*;

	// next byte address of the running download
	dl_addr_t addr;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			ioctl_download <= 1'b0;
			ioctl_index    <= '0;
			ioctl_file_ext <= '0;
			ioctl_wr       <= 1'b0;
			ioctl_addr     <= '0;
			ioctl_dout     <= '0;
			addr           <= '0;
		end else begin
			ioctl_wr <= 1'b0;
			if (word_stb) begin
				case (cmd)
					FILE_INFO: begin
						// extension arrives high half first
						if (word_idx == 10'd1)
							ioctl_file_ext[31:16] <= word;
						else if (word_idx == 10'd2)
							ioctl_file_ext[15:0] <= word;
					end
					FILE_INDEX: begin
						ioctl_index <= word[7:0];
					end
					FILE_TX: begin
						if (|word[7:0]) begin
							addr           <= '0;
							ioctl_download <= 1'b1;
						end else begin
							// stop shows the byte count
							ioctl_addr     <= addr;
							ioctl_download <= 1'b0;
						end
					end
					FILE_TX_DAT: begin
						ioctl_addr <= addr;
						ioctl_dout <= word[7:0];
						ioctl_wr   <= 1'b1;
						addr       <= addr + 1'b1;
					end
					default: begin
					end
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// ==== src/hps_link.sv ====
/*
 * Top level of the command-bus front end: frame tracker, payload
 * registers, file download engine and PS/2 keyboard transmitter.
 */
`timescale 1ns/1ps
`default_nettype none

`include "hps_defs.svh"

module hps_link #(
	parameter int PS2_DIV = `HPS_PS2_DIV
) (
	input  wire                    clk_sys,
	input  wire                    reset,
	input  wire                    io_enable,
	input  wire                    io_strobe,
	input  hps_bus_pkg::word_t     io_din,
	input  wire                    ps2_kbd_clk_in,
	input  wire                    ps2_kbd_data_in,
	output logic [1:0]             buttons,
	output logic                   forced_scandoubler,
	output logic                   direct_video,
	output hps_bus_pkg::joy_t      joystick_0,
	output hps_bus_pkg::joy_t      joystick_1,
	output hps_bus_pkg::status_t   status,
	output logic                   ioctl_download,
	output logic [7:0]             ioctl_index,
	output logic [31:0]            ioctl_file_ext,
	output logic                   ioctl_wr,
	output hps_bus_pkg::dl_addr_t  ioctl_addr,
	output logic [7:0]             ioctl_dout,
	output logic                   ps2_kbd_clk_out,
	output logic                   ps2_kbd_data_out
);
	import hps_bus_pkg::*;

	cmd_e      cmd;
	word_idx_t word_idx;
	word_t     word;
	logic      word_stb;
	cfg_t      cfg;
	logic      ps2_rise;
	logic      ps2_fall;

	hps_cmd_track u_track (
		.clk_sys, .reset, .io_enable, .io_strobe, .io_din,
		.cmd, .word_idx, .word, .word_stb
	);

	////////////////////////////// payload registers

	hps_word_collect #(.payload_t(cfg_t), .CMD_CODE(CFG)) u_cfg (
		.clk_sys, .reset, .cmd, .word_idx, .word, .word_stb, .payload(cfg)
	);

	hps_word_collect #(.payload_t(joy_t), .CMD_CODE(JOY0)) u_joy0 (
		.clk_sys, .reset, .cmd, .word_idx, .word, .word_stb, .payload(joystick_0)
	);

	hps_word_collect #(.payload_t(joy_t), .CMD_CODE(JOY1)) u_joy1 (
		.clk_sys, .reset, .cmd, .word_idx, .word, .word_stb, .payload(joystick_1)
	);

	hps_word_collect #(.payload_t(status_t), .CMD_CODE(STATUS)) u_status (
		.clk_sys, .reset, .cmd, .word_idx, .word, .word_stb, .payload(status)
	);

	// cfg bits 2, 3 and 5 belong to the system top
	assign buttons            = cfg[1:0];
	assign forced_scandoubler = cfg[4];
	assign direct_video       = cfg[10];

	////////////////////////////// download and keyboard

	hps_file_loader u_loader (
		.clk_sys, .reset, .cmd, .word_idx, .word, .word_stb,
		.ioctl_download, .ioctl_index, .ioctl_file_ext,
		.ioctl_wr, .ioctl_addr, .ioctl_dout
	);

	ps2_clk_div #(.DIV(PS2_DIV)) u_ps2_div (
		.clk_sys, .reset, .ps2_rise, .ps2_fall
	);

	ps2_kbd_tx u_kbd (
		.clk_sys, .reset, .cmd, .word_idx, .word, .word_stb,
		.ps2_rise, .ps2_fall, .ps2_kbd_clk_in, .ps2_kbd_data_in,
		.ps2_kbd_clk_out, .ps2_kbd_data_out
	);

endmodule

`default_nettype wire

// ==== src/hps_ps2_pkg.sv ====
/*
 * PS/2 keyboard types: byte, FIFO pointer and transmitter states.
 */
`default_nettype none

`include "hps_defs.svh"

package hps_ps2_pkg;

	typedef logic [7:0] ps2_byte_t;
	typedef logic [`HPS_PS2_FIFO_BITS-1:0] fifo_ptr_t;

	// which part of the frame sits on the data line
	typedef enum logic [1:0] {
		IDLE,
		DATA,
		PARITY,
		STOP
	} ps2_tx_e;

endpackage

`default_nettype wire

// ==== src/hps_word_collect.sv ====
/*
 * Wide payload register filled 16 bits at a time from the data words
 * of one command code.
 */
`timescale 1ns/1ps
`default_nettype none

`include "hps_defs.svh"

module hps_word_collect #(
	parameter type payload_t = hps_bus_pkg::cfg_t,
	parameter hps_bus_pkg::cmd_e CMD_CODE = hps_bus_pkg::CFG
) (
	input  wire                    clk_sys,
	input  wire                    reset,
	input  hps_bus_pkg::cmd_e      cmd,
	input  hps_bus_pkg::word_idx_t word_idx,
	input  hps_bus_pkg::word_t     word,
	input  wire                    word_stb,
	output payload_t               payload
);
	import hps_bus_pkg::*;

	localparam int SLICES = $bits(payload_t) / `HPS_WORD_W;

	// word 1 lands in slice 0, the least significant one
	word_idx_t slot;
	logic      hit;

	assign slot = word_idx - 1'b1;
	assign hit  = word_stb && (cmd == CMD_CODE) && (word_idx != '0) && (int'(slot) < SLICES);

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset)
			payload <= '0;
		else if (hit)
			payload[int'(slot) * `HPS_WORD_W +: `HPS_WORD_W] <= word;
	end

endmodule

`default_nettype wire

// ==== src/ps2_clk_div.sv ====
/*
 * PS/2 clock divider with one-cycle rise and fall pulses.
 */
`timescale 1ns/1ps
`default_nettype none

`include "hps_defs.svh"

module ps2_clk_div #(
	parameter int DIV = `HPS_PS2_DIV
) (
	input  wire  clk_sys,
	input  wire  reset,
	output logic ps2_rise,
	output logic ps2_fall
);
	localparam int CNT_W = (DIV < 1) ? 1 : $clog2(DIV + 1);

	logic [CNT_W-1:0] cnt;
	logic             clk_ps2;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			cnt      <= '0;
			clk_ps2  <= 1'b0;
			ps2_rise <= 1'b0;
			ps2_fall <= 1'b0;
		end else begin
			ps2_rise <= 1'b0;
			ps2_fall <= 1'b0;
			if (cnt == CNT_W'(DIV)) begin
				cnt      <= '0;
				clk_ps2  <= ~clk_ps2;
				// pulse the edge just made
				ps2_rise <= ~clk_ps2;
				ps2_fall <= clk_ps2;
			end else begin
				cnt <= cnt + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== src/ps2_kbd_tx.sv ====
/*
 * Emulated PS/2 keyboard transmit path: byte FIFO fed by the command
 * bus, line synchronizer and the serial frame state machine.
 */
`timescale 1ns/1ps
`default_nettype none

`include "hps_defs.svh"

module ps2_kbd_tx (
	input  wire                    clk_sys,
	input  wire                    reset,
	input  hps_bus_pkg::cmd_e      cmd,
	input  hps_bus_pkg::word_idx_t word_idx,
	input  hps_bus_pkg::word_t     word,
	input  wire                    word_stb,
	input  wire                    ps2_rise,
	input  wire                    ps2_fall,
	input  wire                    ps2_kbd_clk_in,
	input  wire                    ps2_kbd_data_in,
	output logic                   ps2_kbd_clk_out,
	output logic                   ps2_kbd_data_out
);
	import hps_bus_pkg::*;
	import hps_ps2_pkg::*;

	localparam int DEPTH = 1 << `HPS_PS2_FIFO_BITS;

	////////////////////////////// fifo

	ps2_byte_t                   fifo_mem [0:DEPTH-1];
	fifo_ptr_t                   wptr;
	fifo_ptr_t                   rptr;
	logic [`HPS_PS2_FIFO_BITS:0] fill;
	logic                        push;
	logic                        pop;

	// top bit of the fill count marks a full FIFO
	assign push = word_stb && (cmd == PS2_KBD) && (word_idx != '0) && !fill[`HPS_PS2_FIFO_BITS];

	always_ff @(posedge clk_sys) begin
		if (push)
			fifo_mem[wptr] <= word[7:0];
	end

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			wptr <= '0;
			fill <= '0;
		end else begin
			if (push)
				wptr <= wptr + 1'b1;
			case ({push, pop})
				2'b10:   fill <= fill + 1'b1;
				2'b01:   fill <= fill - 1'b1;
				default: fill <= fill;
			endcase
		end
	end

	////////////////////////////// line sync

	logic [1:0] clk_sync;
	logic [1:0] data_sync;
	logic       line_idle;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			clk_sync  <= 2'b11;
			data_sync <= 2'b11;
		end else begin
			clk_sync  <= {clk_sync[0], ps2_kbd_clk_in};
			data_sync <= {data_sync[0], ps2_kbd_data_in};
		end
	end

	// host inhibits by pulling either line low
	assign line_idle = (&clk_sync) && (&data_sync);

	////////////////////////////// transmitter

	ps2_tx_e   state;
	ps2_byte_t tx_byte;
	logic [2:0] bit_cnt;
	logic      parity;
	logic      frame_busy;

	assign pop = ps2_rise && (state == IDLE) && (fill != '0) && line_idle;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			state            <= IDLE;
			tx_byte          <= '0;
			bit_cnt          <= '0;
			parity           <= 1'b1;
			frame_busy       <= 1'b0;
			ps2_kbd_clk_out  <= 1'b1;
			ps2_kbd_data_out <= 1'b1;
		end else if (ps2_rise) begin
			ps2_kbd_clk_out <= 1'b1;
			case (state)
				IDLE: begin
					// stop bit of the last frame ends here
					frame_busy <= 1'b0;
					if (pop) begin
						tx_byte          <= fifo_mem[rptr];
						bit_cnt          <= '0;
						parity           <= 1'b1;
						frame_busy       <= 1'b1;
						ps2_kbd_data_out <= 1'b0;
						state            <= DATA;
					end
				end
				DATA: begin
					// lsb first, parity runs odd
					ps2_kbd_data_out <= tx_byte[0];
					tx_byte          <= {1'b0, tx_byte[7:1]};
					parity           <= parity ^ tx_byte[0];
					bit_cnt          <= bit_cnt + 1'b1;
					if (bit_cnt == 3'd7)
						state <= PARITY;
				end
				PARITY: begin
					ps2_kbd_data_out <= parity;
					state            <= STOP;
				end
				STOP: begin
					ps2_kbd_data_out <= 1'b1;
					state            <= IDLE;
				end
			endcase
		end else if (ps2_fall && frame_busy) begin
			ps2_kbd_clk_out <= 1'b0;
		end
	end

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset)
			rptr <= '0;
		else if (pop)
			rptr <= rptr + 1'b1;
	end

endmodule

`default_nettype wire

// ==== verif/hps_sva.sv ====
/*
 * Concurrent properties on the hps_link ports: single-cycle download
 * writes, strobe-to-write latency and the idle state during reset.
 */
`timescale 1ns/1ps
`default_nettype none

module hps_sva (
	input wire clk_sys,
	input wire reset,
	input wire io_enable,
	input wire io_strobe,
	input wire ioctl_wr,
	input wire ioctl_download,
	input wire ps2_kbd_clk_out,
	input wire ps2_kbd_data_out
);
	// number of failed properties so far
	int unsigned fail_count = 0;

	// one write per data word, never two in a row
	wr_single: assert property (@(posedge clk_sys) disable iff (reset)
		ioctl_wr |=> !ioctl_wr)
	else begin
		$error("ioctl_wr high in two consecutive cycles");
		fail_count++;
	end

	// word strobe at edge N, word_stb at N+1, write seen at N+2
	wr_from_strobe: assert property (@(posedge clk_sys) disable iff (reset)
		ioctl_wr |-> $past(io_enable && io_strobe, 2))
	else begin
		$error("ioctl_wr without a bus strobe two edges earlier");
		fail_count++;
	end

	////////////////////////////// reset state

	reset_idle: assert property (@(posedge clk_sys)
		(reset && $past(reset)) |->
			(!ioctl_wr && !ioctl_download && ps2_kbd_clk_out && ps2_kbd_data_out))
	else begin
		$error("download or PS/2 outputs active during reset");
		fail_count++;
	end

endmodule

bind hps_link hps_sva u_sva (
	.clk_sys          (clk_sys),
	.reset            (reset),
	.io_enable        (io_enable),
	.io_strobe        (io_strobe),
	.ioctl_wr         (ioctl_wr),
	.ioctl_download   (ioctl_download),
	.ps2_kbd_clk_out  (ps2_kbd_clk_out),
	.ps2_kbd_data_out (ps2_kbd_data_out)
);

`default_nettype wire

// ==== verif/hps_tb.sv ====
/*
 * Testbench top: host bus driver, register model, download write
 * monitor and PS/2 frame sampler for hps_link.
 */
`timescale 1ns/1ps
`default_nettype none

module hps_tb #(
	parameter int PS2_DIV = 4
);
	import hps_bus_pkg::*;

	localparam int TIMEOUT  = 20000;
	localparam int DL_BYTES = 12;

	logic        clk_sys;
	logic        reset;
	logic        io_enable;
	logic        io_strobe;
	word_t       io_din;
	logic        ps2_kbd_clk_in;
	logic        ps2_kbd_data_in;
	logic [1:0]  buttons;
	logic        forced_scandoubler;
	logic        direct_video;
	joy_t        joystick_0;
	joy_t        joystick_1;
	status_t     status;
	logic        ioctl_download;
	logic [7:0]  ioctl_index;
	logic [31:0] ioctl_file_ext;
	logic        ioctl_wr;
	dl_addr_t    ioctl_addr;
	logic [7:0]  ioctl_dout;
	logic        ps2_kbd_clk_out;
	logic        ps2_kbd_data_out;

	// register model
	cfg_t        cfg_m;
	joy_t        joy0_m;
	joy_t        joy1_m;
	status_t     status_m;
	logic [7:0]  index_m;
	logic [31:0] ext_m;
	logic        download_m;

	word_t       words [$];
	logic [7:0]  dl_q [$];
	logic [7:0]  kbd_q [$];
	int          wr_count;
	int          fall_count;
	int          falls_before;
	int          bit_n;
	logic [10:0] frame_bits;

	hps_tb_clk u_clk (.clk_sys, .reset);

	hps_link #(.PS2_DIV(PS2_DIV)) UUT (.*);

	////////////////////////////// failure handling

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("TEST FAIL");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic mismatch(input string what);
		stop_run($sformatf("MISMATCH at %0t ns: %s", $time, what));
	endtask

	////////////////////////////// bus driver

	task automatic random_words(input int n);
		for (int i = 0; i < n; i++)
			words.push_back(word_t'($urandom()));
	endtask

	task automatic check_regs();
		assert (buttons == cfg_m[1:0] && forced_scandoubler == cfg_m[4]
			&& direct_video == cfg_m[10])
			else mismatch($sformatf("cfg outputs %b %b %b for cfg word %h",
				buttons, forced_scandoubler, direct_video, cfg_m));
		assert (joystick_0 == joy0_m)
			else mismatch($sformatf("joystick_0 %h expected %h", joystick_0, joy0_m));
		assert (joystick_1 == joy1_m)
			else mismatch($sformatf("joystick_1 %h expected %h", joystick_1, joy1_m));
		assert (status == status_m)
			else mismatch($sformatf("status %h expected %h", status, status_m));
		assert (ioctl_index == index_m)
			else mismatch($sformatf("ioctl_index %h expected %h", ioctl_index, index_m));
		assert (ioctl_file_ext == ext_m)
			else mismatch($sformatf("ioctl_file_ext %h expected %h", ioctl_file_ext, ext_m));
		assert (ioctl_download == download_m)
			else mismatch($sformatf("ioctl_download %b expected %b",
				ioctl_download, download_m));
	endtask

	// code word, then each queued data word with an idle cycle between strobes
	task automatic send_frame(input cmd_e code);
		@(posedge clk_sys);
		#1;
		io_enable = 1'b1;
		io_strobe = 1'b1;
		io_din    = code;
		foreach (words[i]) begin
			@(posedge clk_sys);
			#1;
			io_strobe = 1'b0;
			@(posedge clk_sys);
			#1;
			io_strobe = 1'b1;
			io_din    = words[i];
		end
		@(posedge clk_sys);
		#1;
		io_strobe = 1'b0;
		io_enable = 1'b0;
		words.delete();
		// second edge after the last data strobe
		@(posedge clk_sys);
		#1;
		check_regs();
	endtask

	task automatic idle_cycles(input int n);
		int k;
		k = 0;
		while (k < n) begin
			@(posedge clk_sys);
			k++;
		end
		#1;
	endtask

	// reset is only looked at on a clock edge
	task automatic wait_reset_done();
		int n;
		n = 0;
		do begin
			@(posedge clk_sys);
			n++;
			if (n > 100)
				stop_run("timeout: reset was never released");
		end while (reset);
		#1;
	endtask

	task automatic wait_kbd_drain();
		int n;
		n = 0;
		while (kbd_q.size() != 0) begin
			@(posedge clk_sys);
			n++;
			if (n > TIMEOUT)
				stop_run("timeout: queued PS/2 bytes were not sent");
		end
		#1;
	endtask

	////////////////////////////// monitors

	always @(negedge clk_sys) begin
		if (!reset && ioctl_wr) begin
			assert (dl_q.size() != 0)
				else stop_run("ioctl_wr pulse with no download byte pending");
			assert (ioctl_addr == dl_addr_t'(wr_count))
				else mismatch($sformatf("ioctl_addr %0d expected %0d",
					ioctl_addr, wr_count));
			assert (ioctl_dout == dl_q[0])
				else mismatch($sformatf("ioctl_dout %h expected %h", ioctl_dout, dl_q[0]));
			dl_q.delete(0);
			wr_count++;
		end
		if (UUT.u_sva.fail_count != 0)
			stop_run("a concurrent assertion in hps_sva failed");
	end

	task automatic check_frame(input logic [10:0] f);
		logic [7:0] exp;
		assert (kbd_q.size() != 0)
			else stop_run("PS/2 frame sent with no keyboard byte queued");
		exp = kbd_q.pop_front();
		assert (f[0] == 1'b0) else mismatch("PS/2 start bit is not 0");
		assert (f[8:1] == exp)
			else mismatch($sformatf("PS/2 byte %h expected %h", f[8:1], exp));
		assert ((^f[9:1]) == 1'b1) else mismatch("PS/2 parity is not odd");
		assert (f[10] == 1'b1) else mismatch("PS/2 stop bit is not 1");
	endtask

	// first bit ends up in bit 0 after eleven shifts
	always @(negedge ps2_kbd_clk_out) begin
		if (!reset) begin
			frame_bits = {ps2_kbd_data_out, frame_bits[10:1]};
			fall_count++;
			bit_n++;
			if (bit_n == 11) begin
				bit_n = 0;
				check_frame(frame_bits);
			end
		end
	end

	////////////////////////////// stimulus

	initial begin
		void'($urandom(32'hc47c457f));
		io_enable       = 1'b0;
		io_strobe       = 1'b0;
		io_din          = '0;
		ps2_kbd_clk_in  = 1'b1;
		ps2_kbd_data_in = 1'b1;
		cfg_m           = '0;
		joy0_m          = '0;
		joy1_m          = '0;
		status_m        = '0;
		index_m         = '0;
		ext_m           = '0;
		download_m      = 1'b0;
		wr_count        = 0;
		fall_count      = 0;
		falls_before    = 0;
		bit_n           = 0;
		frame_bits      = '0;
		wait_reset_done();
		check_regs();

		random_words(1);
		cfg_m = words[0];
		send_frame(CFG);

		// third word lies past the joystick width
		random_words(3);
		joy0_m = {words[1], words[0]};
		send_frame(JOY0);
		random_words(2);
		joy1_m = {words[1], words[0]};
		send_frame(JOY1);
		// new frame numbers from word 1 again
		random_words(1);
		joy0_m[15:0] = words[0];
		send_frame(JOY0);
		random_words(6);
		status_m = {words[3], words[2], words[1], words[0]};
		send_frame(STATUS);

		// file download
		random_words(1);
		index_m = words[0][7:0];
		send_frame(FILE_INDEX);
		random_words(2);
		ext_m = {words[0], words[1]};
		send_frame(FILE_INFO);
		words.push_back(word_t'($urandom()) | 16'h0001);
		download_m = 1'b1;
		send_frame(FILE_TX);
		random_words(DL_BYTES);
		foreach (words[i])
			dl_q.push_back(words[i][7:0]);
		send_frame(FILE_TX_DAT);
		words.push_back(word_t'($urandom()) & 16'hff00);
		download_m = 1'b0;
		send_frame(FILE_TX);
		assert (ioctl_addr == dl_addr_t'(DL_BYTES))
			else mismatch($sformatf("byte count %0d expected %0d", ioctl_addr, DL_BYTES));
		assert (wr_count == DL_BYTES && dl_q.size() == 0)
			else mismatch($sformatf("%0d write pulses for %0d bytes", wr_count, DL_BYTES));

		// keyboard frames in push order
		random_words(4);
		foreach (words[i])
			kbd_q.push_back(words[i][7:0]);
		send_frame(PS2_KBD);
		wait_kbd_drain();

		// host inhibits by holding the clock line low
		ps2_kbd_clk_in = 1'b0;
		falls_before   = fall_count;
		random_words(3);
		foreach (words[i])
			kbd_q.push_back(words[i][7:0]);
		send_frame(PS2_KBD);
		idle_cycles(40 * (PS2_DIV + 1));
		assert (fall_count == falls_before && kbd_q.size() == 3)
			else stop_run("PS/2 frame started while the clock line was held low");
		ps2_kbd_clk_in = 1'b1;
		wait_kbd_drain();

		idle_cycles(4);
		if (UUT.u_sva.fail_count == 0) begin
			$display("TEST PASS");
			$finish;
		end else begin
			stop_run("a concurrent assertion in hps_sva failed");
		end
	end

endmodule

`default_nettype wire

// ==== verif/hps_tb_clk.sv ====
/*
 * Testbench clock and reset: 20 ns clock period,
 * reset held high for the first 8 cycles.
 */
`timescale 1ns/1ps
`default_nettype none

module hps_tb_clk #(
	parameter int HALF_PERIOD  = 10,
	parameter int RESET_CYCLES = 8
) (
	output logic clk_sys,
	output logic reset
);
	initial begin
		clk_sys = 1'b0;
		forever #HALF_PERIOD clk_sys = ~clk_sys;
	end

	// release just after an edge so no register sees it change
	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk_sys);
		#1 reset = 1'b0;
	end

endmodule

`default_nettype wire
